/* dv/cache_bank_tb.sv */
`timescale 1ns/1ps
`include "cache_bank_settings.svh"

module cache_bank_tb;
    import cache_bank_pkg::*;

    localparam int CLK_PERIOD_NS  = 20;
    localparam int RESET_CYCLES   = 10;
    localparam int DIRECTED_REQS  = 32;
    localparam int RANDOM_REQS    = 200;
    // request wait, write-back, fill and response all stalled at random
    localparam int MAX_REQ_CYCLES = 64;
    localparam int RRPV_SAT       = (1 << `CB_RRPV_W) - 1;
    localparam int RRPV_NEW       = 2;

    logic                  i_clk;
    logic                  i_nreset;
    pe_req_t               i_req;
    logic                  i_req_valid;
    logic                  o_req_ready;
    pe_rsp_t               o_rsp;
    logic                  o_rsp_valid;
    logic                  i_rsp_ready  = 1'b0;
    dram_wb_t              o_wb;
    logic                  o_wb_valid;
    logic                  i_wb_ready   = 1'b0;
    logic [`CB_ADDR_W-1:0] o_fill_addr;
    logic                  o_fill_ready;
    logic [`CB_LINE_W-1:0] i_fill_data  = '0;
    logic                  i_fill_valid = 1'b0;

    // expected traffic in arrival order
    pe_rsp_t               exp_rsp [$];
    dram_wb_t              exp_wb [$];
    logic [`CB_ADDR_W-1:0] exp_fill [$];

    // reference cache state
    logic                  m_valid [`CB_SETS][`CB_WAYS];
    logic                  m_dirty [`CB_SETS][`CB_WAYS];
    logic [`CB_TAG_W-1:0]  m_tag   [`CB_SETS][`CB_WAYS];
    int                    m_rrpv  [`CB_SETS][`CB_WAYS];
    logic [`CB_LINE_W-1:0] m_line  [`CB_SETS][`CB_WAYS];

    // reference memory and the DRAM that answers the DUT
    logic [`CB_LINE_W-1:0] ref_mem  [logic [`CB_ADDR_W-1:0]];
    logic [`CB_LINE_W-1:0] dram_mem [logic [`CB_ADDR_W-1:0]];

    string                 test_name;
    logic                  stall_on;
    int unsigned           seed_ret;
    logic                  rsp_held = 1'b0;
    pe_rsp_t               rsp_hold;
    logic                  wb_held  = 1'b0;
    dram_wb_t              wb_hold;
    pe_rsp_t               rsp_exp;
    dram_wb_t              wb_exp;
    logic [`CB_ADDR_W-1:0] fill_exp;

    tb_clock_gen u_clock_gen (
        .o_clk    (i_clk),
        .o_nreset (i_nreset)
    );

    cache_bank dut (.*);

    // ----------------------------------------------------------------------
    // reporting
    // ----------------------------------------------------------------------
    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s %s: expected %0h actual %0h",
                     test_name, what, expected, actual);
            $display("Finished with errors");
            $fatal(1, "run stopped at first mismatch");
        end
    endtask

    task automatic stop_on_error(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    // ----------------------------------------------------------------------
    // memory helpers
    // ----------------------------------------------------------------------
    // unwritten lines read back as a mix of their address
    function automatic logic [`CB_LINE_W-1:0] fill_pattern(input logic [`CB_ADDR_W-1:0] addr);
        return {addr ^ 16'h3c5a, ~addr};
    endfunction

    function automatic logic [`CB_LINE_W-1:0] ref_read(input logic [`CB_ADDR_W-1:0] addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return fill_pattern(addr);
    endfunction

    function automatic logic [`CB_LINE_W-1:0] dram_read(input logic [`CB_ADDR_W-1:0] addr);
        if (dram_mem.exists(addr)) begin
            return dram_mem[addr];
        end
        return fill_pattern(addr);
    endfunction

    function automatic logic [`CB_ADDR_W-1:0] make_addr(input int tag, input int set);
        logic [31:0] tag_bits;
        logic [31:0] set_bits;
        tag_bits = tag;
        set_bits = set;
        return {tag_bits[`CB_TAG_W-1:0], set_bits[`CB_SET_W-1:0], {`CB_OFFSET_W{1'b0}}};
    endfunction

    // ----------------------------------------------------------------------
    // reference cache model
    // ----------------------------------------------------------------------
    function automatic void clear_model();
        for (int s = 0; s < `CB_SETS; s++) begin
            for (int w = 0; w < `CB_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_rrpv[s][w]  = 0;
                m_line[s][w]  = '0;
            end
        end
    endfunction

    // saturating age of every valid way but one
    function automatic void age_others(input logic [`CB_SET_W-1:0] set, input int keep);
        for (int w = 0; w < `CB_WAYS; w++) begin
            if (w != keep && m_valid[set][w] && m_rrpv[set][w] < RRPV_SAT) begin
                m_rrpv[set][w] = m_rrpv[set][w] + 1;
            end
        end
    endfunction

    // applies one request and queues the response, write-back and fill it causes
    function automatic void predict_access(input req_op_e op,
                                           input logic [`CB_ADDR_W-1:0] addr,
                                           input logic [`CB_LINE_W-1:0] wline);
        logic [`CB_SET_W-1:0]  set;
        logic [`CB_TAG_W-1:0]  tag;
        logic [`CB_ADDR_W-1:0] line_addr;
        int                    hit_w;
        int                    vic;
        int                    top;
        pe_rsp_t               rsp;
        dram_wb_t              wb;
        set       = addr[`CB_OFFSET_W +: `CB_SET_W];
        tag       = addr[`CB_ADDR_W-1 -: `CB_TAG_W];
        line_addr = {addr[`CB_ADDR_W-1:`CB_OFFSET_W], {`CB_OFFSET_W{1'b0}}};
        hit_w     = -1;
        vic       = -1;
        top       = -1;
        for (int w = 0; w < `CB_WAYS; w++) begin
            if (hit_w < 0 && m_valid[set][w] && m_tag[set][w] == tag) begin
                hit_w = w;
            end
        end
        if (hit_w >= 0) begin
            rsp.hit  = 1'b1;
            rsp.line = m_line[set][hit_w];
            if (op == OP_CONSUME) begin
                m_valid[set][hit_w] = 1'b0;
            end else begin
                age_others(set, hit_w);
                m_rrpv[set][hit_w] = 0;
            end
            if (op == OP_WRITE) begin
                m_dirty[set][hit_w] = 1'b1;
                m_line[set][hit_w]  = wline;
            end else begin
                exp_rsp.push_back(rsp);
            end
        end else if (op == OP_READ || op == OP_CONSUME) begin
            rsp.hit  = 1'b0;
            rsp.line = '0;
            exp_rsp.push_back(rsp);
        end else begin
            // first invalid way or else the lowest way holding the highest value
            for (int w = 0; w < `CB_WAYS; w++) begin
                if (vic < 0 && !m_valid[set][w]) begin
                    vic = w;
                end
            end
            if (vic < 0) begin
                for (int w = 0; w < `CB_WAYS; w++) begin
                    if (m_rrpv[set][w] > top) begin
                        top = m_rrpv[set][w];
                        vic = w;
                    end
                end
            end
            if (m_valid[set][vic] && m_dirty[set][vic]) begin
                wb.addr = {m_tag[set][vic], set, {`CB_OFFSET_W{1'b0}}};
                wb.line = m_line[set][vic];
                ref_mem[wb.addr] = wb.line;
                exp_wb.push_back(wb);
            end
            age_others(set, vic);
            m_valid[set][vic] = 1'b1;
            m_dirty[set][vic] = (op == OP_WRITE);
            m_tag[set][vic]   = tag;
            m_rrpv[set][vic]  = RRPV_NEW;
            if (op == OP_WRITE) begin
                m_line[set][vic] = wline;
            end else begin
                m_line[set][vic] = ref_read(line_addr);
                rsp.hit  = 1'b0;
                rsp.line = m_line[set][vic];
                exp_fill.push_back(line_addr);
                exp_rsp.push_back(rsp);
            end
        end
    endfunction

    // ----------------------------------------------------------------------
    // PE request driver
    // ----------------------------------------------------------------------
    task automatic issue(input req_op_e op, input logic [`CB_ADDR_W-1:0] addr,
                         input logic [`CB_LINE_W-1:0] wline);
        pe_req_t req;
        req.op   = op;
        req.addr = addr;
        req.line = wline;
        predict_access(op, addr, wline);
        @(posedge i_clk);
        i_req       <= req;
        i_req_valid <= 1'b1;
        do begin
            @(negedge i_clk);
        end while (!o_req_ready);
        @(posedge i_clk);
        i_req_valid <= 1'b0;
    endtask

    // wait until the bank is idle with nothing left to see
    task automatic drain();
        do begin
            @(negedge i_clk);
        end while (exp_rsp.size() != 0 || exp_wb.size() != 0 || exp_fill.size() != 0
                   || !o_req_ready);
    endtask

    // DRAM answers and response ready go random once stalls are on
    always @(posedge i_clk) begin
        if (stall_on) begin
            i_rsp_ready  <= 1'($urandom_range(0, 1));
            i_wb_ready   <= 1'($urandom_range(0, 1));
            i_fill_valid <= 1'($urandom_range(0, 1));
        end else begin
            i_rsp_ready  <= 1'b1;
            i_wb_ready   <= 1'b1;
            i_fill_valid <= 1'b1;
        end
        i_fill_data <= dram_read(o_fill_addr);
    end

    // ----------------------------------------------------------------------
    // comparison sampled half a cycle before each edge
    // ----------------------------------------------------------------------
    always @(negedge i_clk) begin
        if (i_nreset) begin
            if (rsp_held) begin
                check_value("held response", 64'({1'b1, rsp_hold}), 64'({o_rsp_valid, o_rsp}));
            end
            if (wb_held) begin
                check_value("held write-back", 64'({1'b1, wb_hold}), 64'({o_wb_valid, o_wb}));
            end
            if (o_rsp_valid && i_rsp_ready) begin
                assert (exp_rsp.size() != 0) else stop_on_error("response with none expected");
                rsp_exp = exp_rsp.pop_front();
                check_value("response", 64'(rsp_exp), 64'(o_rsp));
            end
            if (o_wb_valid && i_wb_ready) begin
                assert (exp_wb.size() != 0) else stop_on_error("write-back with none expected");
                wb_exp = exp_wb.pop_front();
                check_value("write-back", 64'(wb_exp), 64'(o_wb));
                dram_mem[o_wb.addr] = o_wb.line;
            end
            if (o_fill_ready && i_fill_valid) begin
                assert (exp_fill.size() != 0) else stop_on_error("fill with no fetch miss pending");
                fill_exp = exp_fill.pop_front();
                check_value("fill address", 64'(fill_exp), 64'(o_fill_addr));
            end
            rsp_held = o_rsp_valid && !i_rsp_ready;
            rsp_hold = o_rsp;
            wb_held  = o_wb_valid && !i_wb_ready;
            wb_hold  = o_wb;
        end
    end

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        i_req       = '0;
        i_req_valid = 1'b0;
        stall_on    = 1'b0;
        test_name   = "reset";
        seed_ret    = $urandom(32'hc893);
        clear_model();
        wait (i_nreset === 1'b1);
        @(negedge i_clk);
        check_value("idle outputs", 64'(4'b1000),
                    64'({o_req_ready, o_rsp_valid, o_wb_valid, o_fill_ready}));
        issue(OP_READ, make_addr(2, 0), '0);
        issue(OP_CONSUME, make_addr(37, 5), '0);
        drain();

        test_name = "fetch_fill";
        issue(OP_FETCH, make_addr(8, 0), '0);
        issue(OP_READ, make_addr(8, 0), '0);
        drain();

        test_name = "write";
        issue(OP_FETCH, make_addr(16, 1), '0);
        issue(OP_WRITE, make_addr(16, 1), 32'hcafe_0001);
        issue(OP_READ, make_addr(16, 1), '0);
        issue(OP_WRITE, make_addr(80, 2), 32'hcafe_0002);
        issue(OP_READ, make_addr(80, 2), '0);
        drain();

        test_name = "consume";
        issue(OP_FETCH, make_addr(24, 4), '0);
        issue(OP_CONSUME, make_addr(24, 4), '0);
        issue(OP_READ, make_addr(24, 4), '0);
        drain();

        // six dirty lines into set 3 push two of them out
        test_name = "eviction";
        for (int t = 1; t <= 6; t++) begin
            issue(OP_WRITE, make_addr(t, 3), 32'hd000_0000 + t);
        end
        issue(OP_FETCH, make_addr(1, 3), '0);
        issue(OP_FETCH, make_addr(2, 3), '0);
        issue(OP_READ, make_addr(6, 3), '0);
        drain();

        test_name = "backpressure";
        stall_on  = 1'b1;
        for (int n = 0; n < RANDOM_REQS; n++) begin
            repeat ($urandom_range(0, 2)) @(posedge i_clk);
            issue(req_op_e'($urandom_range(0, 3)),
                  make_addr($urandom_range(0, 5), $urandom_range(0, 1)),
                  $urandom);
        end
        drain();

        $display("Finished with no errors");
        $finish;
    end

    // bound on the whole run
    initial begin
        #((DIRECTED_REQS + RANDOM_REQS) * MAX_REQ_CYCLES * CLK_PERIOD_NS
          + RESET_CYCLES * CLK_PERIOD_NS);
        $display("watchdog expired before all requests completed, a handshake is stuck");
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_nreset
);
    localparam int PERIOD_NS    = 20;
    localparam int RESET_CYCLES = 10;

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

    // reset low for the first cycles, released on a rising edge
    initial begin
        o_nreset = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_nreset <= 1'b1;
    end

endmodule

/* hdl/bank_ctrl.sv */
`timescale 1ns/1ps
`include "cache_bank_settings.svh"

module bank_ctrl (
    input  logic                                i_clk,
    input  logic                                i_nreset,
    // PE port
    input  cache_bank_pkg::pe_req_t             i_req,
    input  logic                                i_req_valid,
    output logic                                o_req_ready,
    output cache_bank_pkg::pe_rsp_t             o_rsp,
    output logic                                o_rsp_valid,
    input  logic                                i_rsp_ready,
    // DRAM port
    output cache_bank_pkg::dram_wb_t            o_wb,
    output logic                                o_wb_valid,
    input  logic                                i_wb_ready,
    output logic [`CB_ADDR_W-1:0]               o_fill_addr,
    output logic                                o_fill_ready,
    input  logic [`CB_LINE_W-1:0]               i_fill_data,
    input  logic                                i_fill_valid,
    // way store
    output logic [`CB_SET_W-1:0]                o_rd_set,
    input  cache_bank_pkg::set_meta_t           i_rd_meta,
    input  logic [`CB_WAYS-1:0][`CB_LINE_W-1:0] i_rd_lines,
    output logic                                o_meta_we,
    output logic                                o_data_we,
    output logic [`CB_SET_W-1:0]                o_wr_set,
    output cache_bank_pkg::set_meta_t           o_wr_meta,
    output cache_bank_pkg::way_sel_t            o_wr_way,
    output logic [`CB_LINE_W-1:0]               o_wr_line,
    // victim select
    output logic [`CB_TAG_W-1:0]                o_lookup_tag,
    output cache_bank_pkg::req_op_e             o_lookup_op,
    input  logic                                i_hit,
    input  cache_bank_pkg::way_sel_t            i_hit_way,
    input  cache_bank_pkg::way_sel_t            i_victim_way,
    input  logic                                i_victim_dirty,
    input  cache_bank_pkg::set_meta_t           i_next_meta
);
    import cache_bank_pkg::*;

    bank_state_e state;
    pe_req_t     req_q;
    pe_rsp_t     rsp_q;
    dram_wb_t    wb_q;
    way_sel_t    victim_q;
    set_meta_t   install_q;

    logic [`CB_SET_W-1:0]  req_set;
    logic                  evict_dirty;
    logic                  fill_done;
    logic [`CB_LINE_W-1:0] hit_line;
    logic [`CB_LINE_W-1:0] victim_line;
    logic [`CB_TAG_W-1:0]  victim_tag;

    assign req_set     = req_q.addr[`CB_OFFSET_W +: `CB_SET_W];
    assign evict_dirty = !i_hit && i_victim_dirty;
    assign fill_done   = (state == ST_FILL) && i_fill_valid;

    // handshakes straight from state
    assign o_req_ready  = (state == ST_IDLE);
    assign o_rsp_valid  = (state == ST_RESPOND);
    assign o_wb_valid   = (state == ST_WRITEBACK);
    assign o_fill_ready = (state == ST_FILL);
    assign o_rsp        = rsp_q;
    assign o_wb         = wb_q;
    assign o_fill_addr  = {req_q.addr[`CB_ADDR_W-1:`CB_OFFSET_W], {`CB_OFFSET_W{1'b0}}};

    // read the incoming set while idle so lookup has it next cycle
    assign o_rd_set     = o_req_ready ? i_req.addr[`CB_OFFSET_W +: `CB_SET_W] : req_set;
    assign o_lookup_tag = req_q.addr[`CB_ADDR_W-1 -: `CB_TAG_W];
    assign o_lookup_op  = req_q.op;

    // one-hot muxes over the read ways
    always_comb begin
        hit_line    = '0;
        victim_line = '0;
        victim_tag  = '0;
        for (int w = 0; w < `CB_WAYS; w++) begin
            if (i_hit_way[w]) begin
                hit_line = hit_line | i_rd_lines[w];
            end
            if (i_victim_way[w]) begin
                victim_line = victim_line | i_rd_lines[w];
                victim_tag  = victim_tag | i_rd_meta[w].tag;
            end
        end
    end

    // ----------------------------------------------------------------------
    // array write control
    // ----------------------------------------------------------------------
    always_comb begin
        o_wr_set  = req_set;
        o_meta_we = 1'b0;
        o_data_we = 1'b0;
        o_wr_meta = i_next_meta;
        o_wr_way  = i_hit ? i_hit_way : i_victim_way;
        o_wr_line = req_q.line;
        if (state == ST_LOOKUP) begin
            // writes install right away, fetch misses wait for the fill
            o_meta_we = i_hit || (req_q.op == OP_WRITE);
            o_data_we = (req_q.op == OP_WRITE);
        end else if (fill_done) begin
            o_meta_we = 1'b1;
            o_data_we = 1'b1;
            o_wr_meta = install_q;
            o_wr_way  = victim_q;
            o_wr_line = i_fill_data;
        end
    end

    // ----------------------------------------------------------------------
    // request FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_nreset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_req_valid) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    case (req_q.op)
                        OP_FETCH: begin
                            if (i_hit) begin
                                state <= ST_RESPOND;
                            end else begin
                                state <= evict_dirty ? ST_WRITEBACK : ST_FILL;
                            end
                        end
                        OP_WRITE: state <= evict_dirty ? ST_WRITEBACK : ST_IDLE;
                        default:  state <= ST_RESPOND;
                    endcase
                end
                ST_WRITEBACK: begin
                    if (i_wb_ready) begin
                        state <= (req_q.op == OP_FETCH) ? ST_FILL : ST_IDLE;
                    end
                end
                ST_FILL: begin
                    if (i_fill_valid) begin
                        state <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    if (i_rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request, response and eviction payload
    always_ff @(posedge i_clk) begin
        if (o_req_ready && i_req_valid) begin
            req_q <= i_req;
        end
        if (state == ST_LOOKUP) begin
            rsp_q.hit  <= i_hit;
            rsp_q.line <= i_hit ? hit_line : '0;
            // victim address rebuilt from its tag and this set
            wb_q.addr  <= {victim_tag, req_set, {`CB_OFFSET_W{1'b0}}};
            wb_q.line  <= victim_line;
            victim_q   <= i_victim_way;
            install_q  <= i_next_meta;
        end
        if (fill_done) begin
            rsp_q.hit  <= 1'b0;
            rsp_q.line <= i_fill_data;
        end
    end

endmodule

/* hdl/cache_bank.sv */
`timescale 1ns/1ps
`include "cache_bank_settings.svh"

module cache_bank (
    input  logic                    i_clk,
    input  logic                    i_nreset,
    // PE port
    input  cache_bank_pkg::pe_req_t i_req,
    input  logic                    i_req_valid,
    output logic                    o_req_ready,
    output cache_bank_pkg::pe_rsp_t o_rsp,
    output logic                    o_rsp_valid,
    input  logic                    i_rsp_ready,
    // DRAM port
    output cache_bank_pkg::dram_wb_t o_wb,
    output logic                     o_wb_valid,
    input  logic                     i_wb_ready,
    output logic [`CB_ADDR_W-1:0]    o_fill_addr,
    output logic                     o_fill_ready,
    input  logic [`CB_LINE_W-1:0]    i_fill_data,
    input  logic                     i_fill_valid
);
    import cache_bank_pkg::*;

    // store <-> controller
    logic [`CB_SET_W-1:0]                rd_set;
    set_meta_t                           rd_meta;
    logic [`CB_WAYS-1:0][`CB_LINE_W-1:0] rd_lines;
    logic                                meta_we;
    logic                                data_we;
    logic [`CB_SET_W-1:0]                wr_set;
    set_meta_t                           wr_meta;
    way_sel_t                            wr_way;
    logic [`CB_LINE_W-1:0]               wr_line;

    // selector <-> controller
    logic [`CB_TAG_W-1:0] lookup_tag;
    req_op_e              lookup_op;
    logic                 hit;
    way_sel_t             hit_way;
    way_sel_t             victim_way;
    logic                 victim_dirty;
    set_meta_t            next_meta;

    way_store u_way_store (
        .i_clk      (i_clk),
        .i_nreset   (i_nreset),
        .i_rd_set   (rd_set),
        .o_rd_meta  (rd_meta),
        .o_rd_lines (rd_lines),
        .i_meta_we  (meta_we),
        .i_data_we  (data_we),
        .i_wr_set   (wr_set),
        .i_wr_meta  (wr_meta),
        .i_wr_way   (wr_way),
        .i_wr_line  (wr_line)
    );

    victim_select u_victim_select (
        .i_meta         (rd_meta),
        .i_tag          (lookup_tag),
        .i_op           (lookup_op),
        .o_hit          (hit),
        .o_hit_way      (hit_way),
        .o_victim_way   (victim_way),
        .o_victim_dirty (victim_dirty),
        .o_next_meta    (next_meta)
    );

    bank_ctrl u_bank_ctrl (
        .i_clk          (i_clk),
        .i_nreset       (i_nreset),
        .i_req          (i_req),
        .i_req_valid    (i_req_valid),
        .o_req_ready    (o_req_ready),
        .o_rsp          (o_rsp),
        .o_rsp_valid    (o_rsp_valid),
        .i_rsp_ready    (i_rsp_ready),
        .o_wb           (o_wb),
        .o_wb_valid     (o_wb_valid),
        .i_wb_ready     (i_wb_ready),
        .o_fill_addr    (o_fill_addr),
        .o_fill_ready   (o_fill_ready),
        .i_fill_data    (i_fill_data),
        .i_fill_valid   (i_fill_valid),
        .o_rd_set       (rd_set),
        .i_rd_meta      (rd_meta),
        .i_rd_lines     (rd_lines),
        .o_meta_we      (meta_we),
        .o_data_we      (data_we),
        .o_wr_set       (wr_set),
        .o_wr_meta      (wr_meta),
        .o_wr_way       (wr_way),
        .o_wr_line      (wr_line),
        .o_lookup_tag   (lookup_tag),
        .o_lookup_op    (lookup_op),
        .i_hit          (hit),
        .i_hit_way      (hit_way),
        .i_victim_way   (victim_way),
        .i_victim_dirty (victim_dirty),
        .i_next_meta    (next_meta)
    );

endmodule

/* hdl/cache_bank_pkg.sv */
`include "cache_bank_settings.svh"

package cache_bank_pkg;

    // request kinds from the PE port
    typedef enum logic [1:0] {
        OP_FETCH,
        OP_READ,
        OP_WRITE,
        OP_CONSUME
    } req_op_e;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_FILL,
        ST_RESPOND
    } bank_state_e;

    typedef struct packed {
        req_op_e                op;
        logic [`CB_ADDR_W-1:0] addr;
        logic [`CB_LINE_W-1:0] line;
    } pe_req_t;

    typedef struct packed {
        logic                   hit;
        logic [`CB_LINE_W-1:0] line;
    } pe_rsp_t;

    // dirty victim going back to DRAM, addr is line aligned
    typedef struct packed {
        logic [`CB_ADDR_W-1:0] addr;
        logic [`CB_LINE_W-1:0] line;
    } dram_wb_t;

    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        logic [`CB_TAG_W-1:0]  tag;
        logic [`CB_RRPV_W-1:0] rrpv;
    } way_meta_t;

    typedef way_meta_t [`CB_WAYS-1:0] set_meta_t;

    typedef logic [`CB_WAYS-1:0] way_sel_t;

endpackage

/* hdl/cache_bank_settings.svh */
`ifndef CACHE_BANK_SETTINGS_SVH
`define CACHE_BANK_SETTINGS_SVH

// ----------------------------------------------------------------------
// bank geometry
// ----------------------------------------------------------------------
`define CB_SETS      8
`define CB_WAYS      4
`define CB_ADDR_W    16
`define CB_LINE_W    32

// address split into tag, set index and byte offset
`define CB_OFFSET_W  2
`define CB_SET_W     3
`define CB_TAG_W     (`CB_ADDR_W - `CB_SET_W - `CB_OFFSET_W)

// srrip re-reference value
`define CB_RRPV_W    2

`endif

/* hdl/victim_select.sv */
`timescale 1ns/1ps
`include "cache_bank_settings.svh"

module victim_select (
    input  cache_bank_pkg::set_meta_t i_meta,
    input  logic [`CB_TAG_W-1:0]      i_tag,
    input  cache_bank_pkg::req_op_e   i_op,
    output logic                      o_hit,
    output cache_bank_pkg::way_sel_t  o_hit_way,
    output cache_bank_pkg::way_sel_t  o_victim_way,
    output logic                      o_victim_dirty,
    output cache_bank_pkg::set_meta_t o_next_meta
);
    import cache_bank_pkg::*;

    localparam logic [`CB_RRPV_W-1:0] RRPV_MAX    = '1;
    // new lines start at max minus one
    localparam logic [`CB_RRPV_W-1:0] RRPV_INSERT = {{(`CB_RRPV_W-1){1'b1}}, 1'b0};

    logic [`CB_WAYS-1:0]                 invalid;
    logic [`CB_WAYS-1:0]                 first_invalid;
    logic [`CB_WAYS-1:0]                 dirty_ways;
    logic [`CB_WAYS-1:0]                 max_cand;
    logic [`CB_WAYS-1:0]                 max_way;
    logic [`CB_RRPV_W-1:0]               max_rrpv;
    logic [`CB_WAYS-1:0][`CB_RRPV_W-1:0] aged;

    // tag match and saturating age per way
    always_comb begin
        for (int w = 0; w < `CB_WAYS; w++) begin
            o_hit_way[w]  = i_meta[w].valid && (i_meta[w].tag == i_tag);
            invalid[w]    = !i_meta[w].valid;
            dirty_ways[w] = i_meta[w].valid && i_meta[w].dirty;
            if (i_meta[w].rrpv == RRPV_MAX) begin
                aged[w] = RRPV_MAX;
            end else begin
                aged[w] = i_meta[w].rrpv + 1'b1;
            end
        end
        o_hit = |o_hit_way;
    end

    // ----------------------------------------------------------------------
    // victim choice
    // ----------------------------------------------------------------------
    always_comb begin
        max_rrpv = '0;
        for (int w = 0; w < `CB_WAYS; w++) begin
            if (i_meta[w].rrpv > max_rrpv) begin
                max_rrpv = i_meta[w].rrpv;
            end
        end
        for (int w = 0; w < `CB_WAYS; w++) begin
            max_cand[w] = (i_meta[w].rrpv == max_rrpv);
        end
        // isolate lowest set bit
        first_invalid = invalid & (~invalid + 1'b1);
        max_way       = max_cand & (~max_cand + 1'b1);
        o_victim_way   = (|invalid) ? first_invalid : max_way;
        o_victim_dirty = |(o_victim_way & dirty_ways);
    end

    // ----------------------------------------------------------------------
    // next metadata for a hit or an install
    // ----------------------------------------------------------------------
    always_comb begin
        o_next_meta = i_meta;
        for (int w = 0; w < `CB_WAYS; w++) begin
            if (o_hit) begin
                if (i_op == OP_CONSUME) begin
                    // consume drops the line, no aging
                    if (o_hit_way[w]) begin
                        o_next_meta[w].valid = 1'b0;
                    end
                end else if (o_hit_way[w]) begin
                    o_next_meta[w].rrpv = '0;
                    if (i_op == OP_WRITE) begin
                        o_next_meta[w].dirty = 1'b1;
                    end
                end else if (i_meta[w].valid) begin
                    o_next_meta[w].rrpv = aged[w];
                end
            end else if (o_victim_way[w]) begin
                o_next_meta[w].valid = 1'b1;
                o_next_meta[w].dirty = (i_op == OP_WRITE);
                o_next_meta[w].tag   = i_tag;
                o_next_meta[w].rrpv  = RRPV_INSERT;
            end else if (i_meta[w].valid) begin
                o_next_meta[w].rrpv = aged[w];
            end
        end
    end

endmodule

/* hdl/way_store.sv */
`timescale 1ns/1ps
`include "cache_bank_settings.svh"

module way_store (
    input  logic                                i_clk,
    input  logic                                i_nreset,
    // read port
    input  logic [`CB_SET_W-1:0]                i_rd_set,
    output cache_bank_pkg::set_meta_t           o_rd_meta,
    output logic [`CB_WAYS-1:0][`CB_LINE_W-1:0] o_rd_lines,
    // write port
    input  logic                                i_meta_we,
    input  logic                                i_data_we,
    input  logic [`CB_SET_W-1:0]                i_wr_set,
    input  cache_bank_pkg::set_meta_t           i_wr_meta,
    input  cache_bank_pkg::way_sel_t            i_wr_way,
    input  logic [`CB_LINE_W-1:0]               i_wr_line
);
    import cache_bank_pkg::*;

    // one entry per set, all ways side by side
    set_meta_t                           meta_mem [`CB_SETS];
    logic [`CB_WAYS-1:0][`CB_LINE_W-1:0] line_mem [`CB_SETS];

    // ----------------------------------------------------------------------
    // metadata array
    // ----------------------------------------------------------------------
    // whole set written at once
    always_ff @(posedge i_clk) begin
        if (!i_nreset) begin
            for (int s = 0; s < `CB_SETS; s++) begin
                for (int w = 0; w < `CB_WAYS; w++) begin
                    meta_mem[s][w].valid <= 1'b0;
                end
            end
        end else if (i_meta_we) begin
            meta_mem[i_wr_set] <= i_wr_meta;
        end
    end

    // ----------------------------------------------------------------------
    // line array
    // ----------------------------------------------------------------------
    // only the selected way takes the new line
    always_ff @(posedge i_clk) begin
        if (i_data_we) begin
            for (int w = 0; w < `CB_WAYS; w++) begin
                if (i_wr_way[w]) begin
                    line_mem[i_wr_set][w] <= i_wr_line;
                end
            end
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge i_clk) begin
        o_rd_meta  <= meta_mem[i_rd_set];
        o_rd_lines <= line_mem[i_rd_set];
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the cache bank testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cache_bank_tb \
    -f sim.f -o cache_bank_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/cache_bank_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* sim.f */
+incdir+hdl
hdl/cache_bank_pkg.sv
hdl/way_store.sv
hdl/victim_select.sv
hdl/bank_ctrl.sv
hdl/cache_bank.sv
dv/tb_clock_gen.sv
dv/cache_bank_tb.sv
